// ==== source/radio_ctrl_pkg.sv ====
package radio_ctrl_pkg;

  localparam int TICK_DIV      = 2500;  // 2.5 MHz clocks per ms
  localparam int LED_TICK_BITS = 6;     // LED tick every 64 ms
  localparam int CW_DELAY_MS   = 17;    // Key delay line length

  // Minimum power hold after key up, delay line plus envelope decay
  localparam logic [9:0] KEY_UP_TIMEOUT = 10'd41;

  localparam logic [5:0] ADDR_MODE    = 6'h09;
  localparam logic [5:0] ADDR_CW_HANG = 6'h10;

  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        rqst;           // Single cycle strobe
    logic        requires_resp;
    logic        ptt;
  } cmd_t;

  // Jack pins, all active low
  typedef struct packed {
    logic cw_tip_n;
    logic ptt_ring_n;
    logic inhibit_n;
  } key_in_t;

  typedef struct packed {
    logic inttr;
    logic exttr;
    logic envpa;
    logic envop;
    logic envbias;
    logic rfsw_sel;
  } pa_ctrl_t;

  // 0 lights the LED
  typedef struct packed {
    logic run;
    logic tx;
    logic goodlvl;
    logic clip;
  } led_t;

  typedef enum logic {
    RESP_IDLE,
    RESP_PENDING
  } resp_state_e;

endpackage

// ==== source/radio_resp_pkg.sv ====
package radio_resp_pkg;

  localparam int RESP_W = 40;

  localparam logic [7:0] SERIAL_NO = 8'h00;

  // Slow ADC readings, raw 12 bit counts
  typedef struct packed {
    logic [11:0] fwd_pwr;
    logic [11:0] temperature;
    logic [11:0] rev_pwr;
    logic [11:0] bias_current;
  } telem_t;

  // Telemetry slot carried in bits 36:35 of a status word
  typedef enum logic [1:0] {
    SLOT_ID,
    SLOT_FWD_TEMP,
    SLOT_REV_BIAS,
    SLOT_SPARE
  } slot_e;

endpackage

// ==== source/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen (
  input  logic clk,
  input  logic rst_i,
  output logic ms_tick_o,
  output logic led_tick_o
);
  import radio_ctrl_pkg::*;

  logic [11:0] div_cnt;
  logic [8:0]  ms_cnt;  // Free running ms count

  // Divider wraps after TICK_DIV, so one pulse per TICK_DIV+1 clocks
  always_ff @(posedge clk) begin
    if (rst_i) begin
      div_cnt   <= '0;
      ms_cnt    <= '0;
      ms_tick_o <= 1'b0;
    end else if (div_cnt == 12'(TICK_DIV)) begin
      div_cnt   <= '0;
      ms_cnt    <= ms_cnt + 9'd1;
      ms_tick_o <= 1'b1;
    end else begin
      div_cnt   <= div_cnt + 12'd1;
      ms_tick_o <= 1'b0;
    end
  end

  assign led_tick_o = ms_tick_o & (&ms_cnt[LED_TICK_BITS-1:0]);  // Once per 64 ms

endmodule

// ==== source/led_flash.sv ====
`timescale 1ns/1ps

module led_flash (
  input  logic clk,
  input  logic rst_i,
  input  logic tick_i,
  input  logic event_i,
  output logic led_n_o
);

  typedef enum logic [1:0] {
    CLR,
    SET,
    WAIT1,
    WAIT2
  } flash_state_e;

  flash_state_e state;
  flash_state_e state_next;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= CLR;
    end else begin
      state <= state_next;
    end
  end

  // Lit from the event until the third tick
  always_comb begin
    state_next = state;
    led_n_o    = 1'b0;
    case (state)
      CLR: begin
        led_n_o = 1'b1;  // Dark
        if (event_i) state_next = SET;
      end
      SET: begin
        if (tick_i) state_next = WAIT1;
      end
      WAIT1: begin
        if (tick_i) state_next = WAIT2;
      end
      WAIT2: begin
        if (tick_i) state_next = CLR;
      end
    endcase
  end

  // Lit states keep the LED on until a tick arrives
  a_lit_until_tick: assert property (@(posedge clk) disable iff (rst_i)
    (state != CLR) && !tick_i |=> !led_n_o);

endmodule

// ==== source/cw_sequencer.sv ====
`timescale 1ns/1ps

module cw_sequencer (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       ms_tick_i,
  input  logic       key_down_i,
  input  logic [9:0] hang_ms_i,
  output logic       cw_keydown_o,
  output logic       cw_power_on_o
);
  import radio_ctrl_pkg::*;

  logic [CW_DELAY_MS-1:0] delay_line;  // One ms per stage
  logic [9:0]             hold_cnt;
  logic                   hold_phase;  // 0 min timeout, 1 hang time

  // Key edges keep their spacing, just shifted by CW_DELAY_MS
  always_ff @(posedge clk) begin
    if (rst_i) begin
      delay_line <= '0;
    end else if (ms_tick_i) begin
      delay_line <= {delay_line[CW_DELAY_MS-2:0], key_down_i};
    end
  end

  assign cw_keydown_o = delay_line[CW_DELAY_MS-1];

  // Power comes up at once so the T/R relay settles before the envelope
  always_ff @(posedge clk) begin
    if (rst_i) begin
      hold_cnt      <= '0;
      hold_phase    <= 1'b0;
      cw_power_on_o <= 1'b0;
    end else if (key_down_i) begin
      hold_cnt      <= KEY_UP_TIMEOUT;  // Restart on every key-down cycle
      hold_phase    <= 1'b0;
      cw_power_on_o <= 1'b1;
    end else if (ms_tick_i) begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 10'd1;
      end else if (!hold_phase) begin
        hold_cnt   <= hang_ms_i;      // Extra hang from host
        hold_phase <= 1'b1;
      end else begin
        cw_power_on_o <= 1'b0;
      end
    end
  end

  // Envelope must never run without PA power
  a_key_has_power: assert property (@(posedge clk) disable iff (rst_i)
    cw_keydown_o |-> cw_power_on_o);

endmodule

// ==== source/tx_ctrl.sv ====
`timescale 1ns/1ps

module tx_ctrl (
  input  logic                     clk,
  input  logic                     rst_i,
  input  radio_ctrl_pkg::cmd_t     cmd_i,
  input  radio_ctrl_pkg::key_in_t  key_i,
  input  logic                     run_i,
  input  logic                     cw_keydown_i,
  input  logic                     cw_power_on_i,
  output logic                     tx_on_o,
  output radio_ctrl_pkg::pa_ctrl_t pa_o,
  output logic [9:0]               hang_ms_o,
  output logic                     key_down_o,
  output logic                     ptt_o,
  output logic                     cw_key_o
);
  import radio_ctrl_pkg::*;

  key_in_t key_meta;
  key_in_t key_sync;
  logic    int_ptt;
  logic    vna;         // VNA mode, PA bypassed
  logic    pa_enable;
  logic    tr_disable;
  logic    power_on;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      key_meta <= '1;  // Pins idle high
      key_sync <= '1;
    end else begin
      key_meta <= key_i;
      key_sync <= key_meta;
    end
  end

  assign key_down_o = ~key_sync.cw_tip_n;
  assign cw_key_o   = ~key_sync.cw_tip_n;
  assign ptt_o      = ~key_sync.ptt_ring_n;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      int_ptt    <= 1'b0;
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
      hang_ms_o  <= '0;
    end else if (cmd_i.rqst) begin
      int_ptt <= cmd_i.ptt;  // Every command carries PTT
      if (cmd_i.addr == ADDR_MODE) begin
        vna        <= cmd_i.data[23];
        pa_enable  <= cmd_i.data[19];
        tr_disable <= cmd_i.data[18];
      end else if (cmd_i.addr == ADDR_CW_HANG) begin
        hang_ms_o <= {cmd_i.data[31:24], cmd_i.data[17:16]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_on_o <= 1'b0;
    end else begin
      tx_on_o <= (int_ptt | cw_keydown_i | ptt_o) & key_sync.inhibit_n & run_i;
    end
  end

  assign power_on = cw_power_on_i | tx_on_o;

  always_comb begin
    pa_o.inttr    = power_on & ~vna & (pa_enable | ~tr_disable);
    pa_o.exttr    = power_on;
    pa_o.envop    = power_on;
    pa_o.envpa    = power_on & ~vna & pa_enable;
    pa_o.envbias  = power_on & ~vna & pa_enable;
    pa_o.rfsw_sel = ~vna & pa_enable;  // Antenna path, not tied to TX
  end

endmodule

// ==== source/resp_builder.sv ====
`timescale 1ns/1ps

module resp_builder (
  input  logic                              clk,
  input  logic                              rst_i,
  input  radio_ctrl_pkg::cmd_t              cmd_i,
  input  logic                              resp_rqst_i,
  input  logic                              tx_on_i,
  input  logic                              ptt_i,
  input  logic                              cw_key_i,
  input  logic                              rxclip_i,
  input  radio_resp_pkg::telem_t            telem_i,
  output logic [radio_resp_pkg::RESP_W-1:0] resp_o
);
  import radio_ctrl_pkg::*;
  import radio_resp_pkg::*;

  resp_state_e state;
  resp_state_e state_next;
  logic [5:0]  echo_addr;
  logic [31:0] echo_data;
  slot_e       slot;
  logic [1:0]  clip_cnt;      // Saturates at 3
  logic [31:0] slot_payload;
  logic        new_echo;

  assign new_echo = cmd_i.rqst & cmd_i.requires_resp;

  // A newer command overwrites the pending echo
  always_comb begin
    state_next = state;
    case (state)
      RESP_IDLE: begin
        if (new_echo) state_next = RESP_PENDING;
      end
      RESP_PENDING: begin
        if (resp_rqst_i && !new_echo) state_next = RESP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= RESP_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      echo_addr <= '0;
      echo_data <= '0;
    end else if (new_echo) begin
      echo_addr <= cmd_i.addr;
      echo_data <= cmd_i.data;
    end
  end

  always_comb begin
    case (slot)
      SLOT_ID:       slot_payload = {7'b0001111, &clip_cnt, 16'h0000, SERIAL_NO};
      SLOT_FWD_TEMP: slot_payload = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      SLOT_REV_BIAS: slot_payload = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      SLOT_SPARE:    slot_payload = '0;
    endcase
  end

  // Word only moves on a request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      resp_o   <= '0;
      slot     <= SLOT_ID;
      clip_cnt <= '0;
    end else if (resp_rqst_i) begin
      clip_cnt <= '0;
      slot     <= slot_e'(slot + 2'd1);  // Skipped if echo goes out instead
      if (state == RESP_PENDING) begin
        resp_o <= {1'b1, echo_addr, tx_on_i, echo_data};
      end else begin
        resp_o <= {3'b000, slot, 1'b0, cw_key_i, ptt_i, slot_payload};
      end
    end else if (!(&clip_cnt)) begin
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  // Echo is never lost to a slot word
  a_echo_sent: assert property (@(posedge clk) disable iff (rst_i)
    new_echo ##1 resp_rqst_i[->1] |=> resp_o[RESP_W-1]);

endmodule

// ==== source/radio_ctrl_top.sv ====
`timescale 1ns/1ps

module radio_ctrl_top (
  input  logic                              clk,
  input  logic                              rst_i,
  input  radio_ctrl_pkg::cmd_t              cmd_i,
  input  radio_ctrl_pkg::key_in_t           key_i,
  input  logic                              run_i,
  input  logic                              rxclip_i,
  input  logic                              rxgoodlvl_i,
  input  radio_resp_pkg::telem_t            telem_i,
  input  logic                              resp_rqst_i,
  output logic                              tx_on_o,
  output logic                              cw_keydown_o,
  output radio_ctrl_pkg::pa_ctrl_t          pa_o,
  output radio_ctrl_pkg::led_t              led_o,
  output logic [radio_resp_pkg::RESP_W-1:0] resp_o
);

  logic       ms_tick;
  logic       led_tick;
  logic       cw_keydown;
  logic       cw_power_on;
  logic       tx_on;
  logic [9:0] hang_ms;
  logic       key_down;
  logic       ptt;
  logic       cw_key;
  logic       goodlvl_n;
  logic       clip_n;

  tick_gen u_tick (
    .clk       (clk),
    .rst_i     (rst_i),
    .ms_tick_o (ms_tick),
    .led_tick_o(led_tick)
  );

  led_flash u_flash_goodlvl (
    .clk    (clk),
    .rst_i  (rst_i),
    .tick_i (led_tick),
    .event_i(rxgoodlvl_i),
    .led_n_o(goodlvl_n)
  );

  led_flash u_flash_clip (
    .clk    (clk),
    .rst_i  (rst_i),
    .tick_i (led_tick),
    .event_i(rxclip_i),
    .led_n_o(clip_n)
  );

  cw_sequencer u_cw (
    .clk          (clk),
    .rst_i        (rst_i),
    .ms_tick_i    (ms_tick),
    .key_down_i   (key_down),
    .hang_ms_i    (hang_ms),
    .cw_keydown_o (cw_keydown),
    .cw_power_on_o(cw_power_on)
  );

  tx_ctrl u_tx (
    .clk          (clk),
    .rst_i        (rst_i),
    .cmd_i        (cmd_i),
    .key_i        (key_i),
    .run_i        (run_i),
    .cw_keydown_i (cw_keydown),
    .cw_power_on_i(cw_power_on),
    .tx_on_o      (tx_on),
    .pa_o         (pa_o),
    .hang_ms_o    (hang_ms),
    .key_down_o   (key_down),
    .ptt_o        (ptt),
    .cw_key_o     (cw_key)
  );

  resp_builder u_resp (
    .clk        (clk),
    .rst_i      (rst_i),
    .cmd_i      (cmd_i),
    .resp_rqst_i(resp_rqst_i),
    .tx_on_i    (tx_on),
    .ptt_i      (ptt),
    .cw_key_i   (cw_key),
    .rxclip_i   (rxclip_i),
    .telem_i    (telem_i),
    .resp_o     (resp_o)
  );

  assign tx_on_o      = tx_on;
  assign cw_keydown_o = cw_keydown;

  // All dark when the host is not running
  always_comb begin
    led_o.run     = ~run_i;
    led_o.tx      = run_i ? ~tx_on : 1'b1;
    led_o.goodlvl = run_i ? goodlvl_n : 1'b1;
    led_o.clip    = run_i ? clip_n : 1'b1;
  end

endmodule

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic                              clk,
  input  radio_ctrl_pkg::cmd_t              cmd_i,
  input  radio_ctrl_pkg::key_in_t           key_i,
  input  logic                              run_i,
  input  logic                              rxclip_i,
  input  radio_resp_pkg::telem_t            telem_i,
  input  logic                              resp_rqst_i,
  input  logic                              tx_on_i,
  input  logic                              cw_keydown_i,
  input  radio_ctrl_pkg::pa_ctrl_t          pa_i,
  input  radio_ctrl_pkg::led_t              led_i,
  input  logic [radio_resp_pkg::RESP_W-1:0] resp_i,
  output int                                errors_o
);
  import radio_ctrl_pkg::*;
  import radio_resp_pkg::*;

  int                errors       = 0;
  int                tests_run    = 0;
  int                tests_failed = 0;
  int                test_errors  = 0;
  logic              test_open    = 1'b0;
  string             test_name;
  logic              echo_due     = 1'b0;  // Command echo waiting for a request
  logic [5:0]        echo_addr    = '0;
  logic [31:0]       echo_data    = '0;
  logic [1:0]        clip_seen    = '0;    // Clip cycles since last request
  logic              int_ptt      = 1'b0;  // PTT bit of the last command
  int                cw_idle      = 0;     // Cycles since the CW tip was down
  logic              req_echo     = 1'b0;
  logic              req_clip_sat = 1'b0;
  logic              req_ptt      = 1'b0;
  logic              req_cw       = 1'b0;
  logic              req_cw_idle  = 1'b0;
  logic              req_tx       = 1'b0;
  logic [RESP_W-1:0] echo_word    = '0;

  assign errors_o = errors;

  // Host side model of the response path
  always @(negedge clk) begin
    if (resp_rqst_i) begin
      req_echo     = echo_due;
      req_clip_sat = &clip_seen;
      req_ptt      = ~key_i.ptt_ring_n;
      req_cw       = ~key_i.cw_tip_n;
      req_cw_idle  = cw_idle >= (CW_DELAY_MS + 2) * (TICK_DIV + 1);
      req_tx       = (int_ptt | ~key_i.ptt_ring_n) & key_i.inhibit_n & run_i;
      echo_word    = {1'b1, echo_addr, req_tx, echo_data};
      clip_seen    = 2'd0;
      echo_due     = 1'b0;
    end else if (rxclip_i && clip_seen != 2'd3) begin
      clip_seen = clip_seen + 2'd1;
    end
    if (!key_i.cw_tip_n) begin
      cw_idle = 0;
    end else if (cw_idle < (CW_DELAY_MS + 2) * (TICK_DIV + 1)) begin
      cw_idle++;
    end
    if (cmd_i.rqst) begin
      int_ptt = cmd_i.ptt;
    end
    if (cmd_i.rqst && cmd_i.requires_resp) begin
      echo_due  = 1'b1;  // Newer command replaces an older one
      echo_addr = cmd_i.addr;
      echo_data = cmd_i.data;
    end
  end

  function automatic string port_name(input string sig);
    if (sig == "tx") return "tx_on_o";
    if (sig == "keydown") return "cw_keydown_o";
    if (sig == "pa") return "pa_o";
    if (sig == "exttr") return "pa_o.exttr";
    if (sig == "led") return "led_o";
    if (sig == "ledclip") return "led_o.clip";
    if (sig == "resp") return "resp_o";
    return "";
  endfunction

  function automatic logic [63:0] probe(input string sig);
    if (sig == "tx") return 64'(tx_on_i);
    if (sig == "keydown") return 64'(cw_keydown_i);
    if (sig == "pa") return 64'(pa_i);
    if (sig == "exttr") return 64'(pa_i.exttr);
    if (sig == "led") return 64'(led_i);
    if (sig == "ledclip") return 64'(led_i.clip);
    return 64'(resp_i);
  endfunction

  // Status word for one slot
  function automatic logic [RESP_W-1:0] slot_word(input logic [1:0] slot);
    logic [31:0] payload;
    case (slot)
      2'd0:    payload = {7'b0001111, req_clip_sat, 16'h0000, SERIAL_NO};
      2'd1:    payload = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      2'd2:    payload = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      default: payload = 32'h0;
    endcase
    return {3'b000, slot, 1'b0, req_cw, req_ptt, payload};
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic close_test();
    if (test_open) begin
      tests_run++;
      if (test_errors != 0) tests_failed++;
      $display("test %-14s %s (%0d errors)", test_name,
               (test_errors == 0) ? "passed" : "FAILED", test_errors);
      test_open = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    close_test();
    test_name   = name;
    test_errors = 0;
    test_open   = 1'b1;
  endtask

  // Level must show up within timeout cycles
  task automatic check_level(input string sig, input logic [63:0] value, input int timeout);
    int          waited;
    logic [63:0] seen;
    if (port_name(sig) == "") begin
      $display("check asks for unknown signal %s", sig);
      note_error();
      return;
    end
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      seen = probe(sig);
    end while (seen !== value && waited < timeout);
    if (seen !== value) begin
      $display("[ERROR] %s = 0x%0h, expected 0x%0h", port_name(sig), seen, value);
      note_error();
    end
  endtask

  // Time to the change in ms ticks of TICK_DIV+1 clocks
  task automatic measure_ticks(input string sig, input logic [63:0] value,
                               input int min_t, input int max_t);
    int cycles;
    int ticks;
    int limit;
    limit  = (max_t + 1) * (TICK_DIV + 1);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (probe(sig) !== value && cycles < limit);
    if (probe(sig) !== value) begin
      $display("%s did not reach 0x%0h within %0d ms ticks", port_name(sig), value, max_t + 1);
      note_error();
      return;
    end
    ticks = (cycles + TICK_DIV) / (TICK_DIV + 1);  // Partial tick counts as one
    if (ticks < min_t || ticks > max_t) begin
      $display("[ERROR] %s changed after 0x%0h ms ticks, expected 0x%0h to 0x%0h",
               port_name(sig), ticks, min_t, max_t);
      note_error();
    end
  endtask

  task automatic compare_resp(input logic [RESP_W-1:0] expected);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (resp_i !== expected && waited < 4);
    if (resp_i !== expected) begin
      $display("[ERROR] resp_o = 0x%010h, expected 0x%010h", resp_i, expected);
      note_error();
    end
  endtask

  task automatic check_slot(input logic [1:0] slot);
    compare_resp(slot_word(slot));
  endtask

  task automatic check_echo();
    if (!req_echo) begin
      $display("no command echo was due at the last response request");
      note_error();
    end
    if (!req_cw_idle) begin
      $display("echo request came too soon after CW keying to predict tx_on");
      note_error();
    end
    compare_resp(echo_word);
  endtask

  task automatic print_counts();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import radio_ctrl_pkg::*;
  import radio_resp_pkg::*;

  logic              clk = 1'b0;
  logic              rst_i;
  cmd_t              cmd;
  key_in_t           key;
  logic              run;
  logic              rxclip;
  logic              rxgoodlvl;
  telem_t            telem;
  logic              resp_rqst;
  logic              tx_on;
  logic              cw_keydown;
  pa_ctrl_t          pa;
  led_t              led;
  logic [RESP_W-1:0] resp;
  int                errors;
  logic              file_ok;

  always #10 clk = ~clk;  // 20 ns period

  radio_ctrl_top dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .cmd_i       (cmd),
    .key_i       (key),
    .run_i       (run),
    .rxclip_i    (rxclip),
    .rxgoodlvl_i (rxgoodlvl),
    .telem_i     (telem),
    .resp_rqst_i (resp_rqst),
    .tx_on_o     (tx_on),
    .cw_keydown_o(cw_keydown),
    .pa_o        (pa),
    .led_o       (led),
    .resp_o      (resp)
  );

  tb_checker chk (
    .clk         (clk),
    .cmd_i       (cmd),
    .key_i       (key),
    .run_i       (run),
    .rxclip_i    (rxclip),
    .telem_i     (telem),
    .resp_rqst_i (resp_rqst),
    .tx_on_i     (tx_on),
    .cw_keydown_i(cw_keydown),
    .pa_i        (pa),
    .led_i       (led),
    .resp_i      (resp),
    .errors_o    (errors)
  );

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data,
                          input logic need_resp, input logic ptt);
    @(posedge clk);
    cmd.addr          <= addr;
    cmd.data          <= data;
    cmd.requires_resp <= need_resp;
    cmd.ptt           <= ptt;
    cmd.rqst          <= 1'b1;
    @(posedge clk);
    cmd.rqst <= 1'b0;  // Host strobe is one cycle
  endtask

  task automatic set_keys(input logic tip_n, input logic ring_n, input logic inhibit_n);
    @(posedge clk);
    key.cw_tip_n   <= tip_n;
    key.ptt_ring_n <= ring_n;
    key.inhibit_n  <= inhibit_n;
  endtask

  task automatic set_levels(input logic run_lvl, input logic good_lvl, input logic clip_lvl,
                            input telem_t telem_lvl);
    @(posedge clk);
    run       <= run_lvl;
    rxgoodlvl <= good_lvl;
    rxclip    <= clip_lvl;
    telem     <= telem_lvl;
  endtask

  task automatic request_resp();
    @(posedge clk);
    resp_rqst <= 1'b1;
    @(posedge clk);
    resp_rqst <= 1'b0;
  endtask

  // Stimulus player reading one record per line
  initial begin
    int          fd;
    int          nrec;
    int          code;
    string       kind;
    string       word;
    string       rest;
    logic [63:0] f0;
    logic [63:0] f1;
    logic [63:0] f2;
    logic [63:0] f3;
    logic [63:0] f4;
    logic [63:0] f5;
    logic [63:0] f6;
    rst_i     = 1'b1;
    cmd       = '0;
    key       = '1;  // Jack pins idle high
    run       = 1'b0;
    rxclip    = 1'b0;
    rxgoodlvl = 1'b0;
    telem     = '0;
    resp_rqst = 1'b0;
    file_ok   = 1'b1;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    fd = $fopen("tests/radio_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/radio_stim.txt");
      file_ok = 1'b0;
    end else begin
      nrec = 0;
      while (nrec < 500 && $fscanf(fd, "%s", kind) == 1) begin
        nrec++;
        if (kind == "#") begin
          code = $fgets(rest, fd);
        end else if (kind == "T") begin
          code = $fscanf(fd, "%s", word);
          chk.start_test(word);
        end else if (kind == "C") begin
          code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          send_cmd(f0[5:0], f1[31:0], f2[0], f3[0]);
        end else if (kind == "K") begin
          code = $fscanf(fd, "%h %h %h", f0, f1, f2);
          set_keys(f0[0], f1[0], f2[0]);
        end else if (kind == "L") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
          set_levels(f0[0], f1[0], f2[0], {f3[11:0], f4[11:0], f5[11:0], f6[11:0]});
        end else if (kind == "R") begin
          request_resp();
        end else if (kind == "W") begin
          code = $fscanf(fd, "%h", f0);
          repeat (int'(f0[19:0])) @(posedge clk);
        end else if (kind == "E") begin
          code = $fscanf(fd, "%s %h %h", word, f0, f1);
          chk.check_level(word, f0, int'(f1[15:0]));
        end else if (kind == "M") begin
          code = $fscanf(fd, "%s %h %h %h", word, f0, f1, f2);
          chk.measure_ticks(word, f0, int'(f1[15:0]), int'(f2[15:0]));
        end else if (kind == "S") begin
          code = $fscanf(fd, "%h", f0);
          chk.check_slot(f0[1:0]);
        end else if (kind == "X") begin
          chk.check_echo();
        end else begin
          $display("unknown record %s in the stimulus file", kind);
          file_ok = 1'b0;
        end
      end
      $fclose(fd);
    end
    chk.close_test();
    chk.print_counts();
    if (errors == 0 && file_ok) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/radio_stim.txt ====
# Fields in hex: T name | C addr data need_resp ptt | K tip_n ring_n inhibit_n | R | W cycles
# L run goodlvl clip fwd temp rev bias | E sig value timeout | M sig value min_ticks max_ticks | S slot | X
T reset
E tx 0 1
E keydown 0 1
E pa 0 1
E led f 1
E resp 0 1
T mode_write
L 1 0 0 123 456 789 abc
C 09 00080000 0 1
E tx 1 4
E pa 3f 4
C 09 00880000 0 1
E pa 14 4
E tx 1 4
T inhibit
K 1 1 0
E tx 0 4
K 1 1 1
E tx 1 4
L 0 0 0 123 456 789 abc
E tx 0 4
E led f 4
L 1 0 0 123 456 789 abc
E tx 1 4
E led 3 4
T clip_flash
C 09 00080000 0 0
E tx 0 4
L 1 0 1 123 456 789 abc
L 1 0 0 123 456 789 abc
E ledclip 0 4
M ledclip 1 80 c0
T cw_key
C 10 01010000 0 0
E pa 01 4
K 0 1 1
E exttr 1 4
M keydown 1 10 12
K 1 1 1
M exttr 0 2e 31
E keydown 0 1
T resp_rotation
K 1 0 1
W 4
L 1 0 1 123 456 789 abc
L 1 0 1 123 456 789 abc
L 1 0 1 123 456 789 abc
L 1 0 0 123 456 789 abc
R
S 0
R
S 1
R
S 2
R
S 3
T cmd_echo
C 2a 12345678 1 0
R
X
R
S 1

// ==== list.f ====
source/radio_ctrl_pkg.sv
source/radio_resp_pkg.sv
source/tick_gen.sv
source/led_flash.sv
source/cw_sequencer.sv
source/tx_ctrl.sv
source/resp_builder.sv
source/radio_ctrl_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_sim &&
  out=$(./obj_dir/tb_sim) &&
  echo "$out" &&
  echo "$out" | grep -qx '>>> PASS' ||
  { echo "simulation did not pass"; exit 1; }
